// File: src/soc_pkg.sv
package soc_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 64;

    // load/store type as driven by the core
    // bit 2 set means zero extension, bits 1:0 give the access size
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_t;

    // priority and threshold width
    localparam int prio_w = 3;

    // default sizes
    // 32-bit words of on-chip RAM
    localparam int default_ram_words   = 256;
    // source ids, id 0 reserved
    localparam int default_num_sources = 6;

    // address map
    localparam logic [addr_w-1:0] ram_base  = 32'h0000_0000;
    localparam logic [addr_w-1:0] key_addr  = 32'h1000_0000;
    localparam logic [addr_w-1:0] plic_base = 32'h0C00_0000;

    // interrupt controller offsets from plic_base
    // priority registers sit at 4 * source id
    localparam logic [addr_w-1:0] plic_pending_off       = 32'h0000_1000;
    localparam logic [addr_w-1:0] plic_enable_off        = 32'h0000_2000;
    localparam logic [addr_w-1:0] plic_ctx_enable_stride = 32'h0000_0080;
    localparam logic [addr_w-1:0] plic_threshold_off     = 32'h0020_0000;
    localparam logic [addr_w-1:0] plic_claim_off         = 32'h0020_0004;
    localparam logic [addr_w-1:0] plic_ctx_stride        = 32'h0000_1000;
    localparam logic [addr_w-1:0] plic_span              = 32'h0040_0000;

endpackage

// File: src/plic_target.sv
`timescale 1ns/1ps

module plic_target import soc_pkg::*; #(
    parameter int num_sources = default_num_sources
) (
    input  logic [num_sources-1:0]             candidates,
    input  logic [num_sources-1:0][prio_w-1:0] priorities,
    input  logic [prio_w-1:0]                  threshold,
    output logic [$clog2(num_sources)-1:0]     claim_id
);

    localparam int id_w = $clog2(num_sources);

    logic [prio_w-1:0] best_prio;

    // scan upward, strictly greater keeps the lowest id on ties
    // starting at threshold means an equal priority never wins
    always_comb begin
        best_prio = threshold;
        claim_id  = '0;
        for (int i = 1; i < num_sources; i++) begin
            if (candidates[i] && (priorities[i] > best_prio)) begin
                best_prio = priorities[i];
                claim_id  = id_w'(i);
            end
        end
    end

endmodule

// File: src/plic_regs.sv
`timescale 1ns/1ps

module plic_regs import soc_pkg::*; #(
    parameter int num_sources = default_num_sources
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   plic_access,
    input  logic                   plic_write,
    input  logic [addr_w-1:0]      plic_offset,
    input  logic [31:0]            plic_wdata,
    input  logic                   key_event,
    input  logic [num_sources-1:0] ext_irq,
    output logic [31:0]            plic_rdata,
    output logic                   meip,
    output logic                   seip
);

    localparam int id_w    = $clog2(num_sources);
    localparam int num_ctx = 2;

    logic [num_sources-1:0][prio_w-1:0] prio;
    logic [num_sources-1:0]             pending;
    logic [num_sources-1:0]             pending_set;
    logic [num_sources-1:0]             pending_clr;
    logic [num_ctx-1:0][num_sources-1:0] enable;
    logic [num_ctx-1:0][prio_w-1:0]     threshold;
    logic [num_ctx-1:0][id_w-1:0]       claim_id;
    logic [num_ctx-1:0]                 enable_hit;
    logic [num_ctx-1:0]                 threshold_hit;
    logic [num_ctx-1:0]                 claim_hit;
    logic [id_w-1:0]                    prio_id;
    logic                               prio_hit;
    logic                               pending_hit;
    logic                               rd;
    logic                               wr;

    assign rd = plic_access && !plic_write;
    assign wr = plic_access && plic_write;

    // priority window, id 0 has no register
    assign prio_id  = plic_offset[id_w+1:2];
    assign prio_hit = (plic_offset < addr_w'(num_sources * 4)) &&
                      (plic_offset[1:0] == 2'b00) && (prio_id != '0);
    assign pending_hit = (plic_offset == plic_pending_off);

    // context 0 is machine level, context 1 supervisor level
    for (genvar ctx = 0; ctx < num_ctx; ctx++) begin : g_ctx
        assign enable_hit[ctx]    = plic_offset == plic_enable_off + ctx * plic_ctx_enable_stride;
        assign threshold_hit[ctx] = plic_offset == plic_threshold_off + ctx * plic_ctx_stride;
        assign claim_hit[ctx]     = plic_offset == plic_claim_off + ctx * plic_ctx_stride;

        plic_target #(.num_sources(num_sources)) u_target (
            .candidates (pending & enable[ctx]),
            .priorities (prio),
            .threshold  (threshold[ctx]),
            .claim_id   (claim_id[ctx])
        );
    end

    // read mux, unknown offsets and claim writes give 0
    always_comb begin
        plic_rdata = '0;
        if (prio_hit) begin
            plic_rdata = 32'(prio[prio_id]);
        end
        if (pending_hit) begin
            plic_rdata = 32'(pending);
        end
        for (int c = 0; c < num_ctx; c++) begin
            if (enable_hit[c]) plic_rdata = 32'(enable[c]);
            if (threshold_hit[c]) plic_rdata = 32'(threshold[c]);
            if (claim_hit[c]) plic_rdata = 32'(claim_id[c]);
        end
    end

    // id 0 never pends, so a claim of 0 clears nothing
    always_comb begin
        pending_set = ext_irq;
        pending_set[0] = 1'b0;
        if (key_event) begin
            pending_set[1] = 1'b1;
        end
        pending_clr = '0;
        for (int c = 0; c < num_ctx; c++) begin
            if (rd && claim_hit[c]) begin
                pending_clr[claim_id[c]] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio      <= '0;
            pending   <= '0;
            enable    <= '0;
            threshold <= '0;
            meip      <= 1'b0;
            seip      <= 1'b0;
        end else begin
            // a line still high re-pends right after its claim
            pending <= (pending & ~pending_clr) | pending_set;
            if (wr) begin
                if (prio_hit) begin
                    prio[prio_id] <= plic_wdata[prio_w-1:0];
                end
                for (int c = 0; c < num_ctx; c++) begin
                    if (enable_hit[c]) enable[c] <= plic_wdata[num_sources-1:0];
                    if (threshold_hit[c]) threshold[c] <= plic_wdata[prio_w-1:0];
                end
            end
            meip <= (claim_id[0] != '0);
            seip <= (claim_id[1] != '0);
        end
    end

endmodule

// File: src/word_ram.sv
`timescale 1ns/1ps

module word_ram import soc_pkg::*; #(
    parameter int ram_words = default_ram_words
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         ram_start,
    input  logic                         ram_write,
    input  logic [$clog2(ram_words)-1:0] ram_word_index,
    input  logic [1:0]                   ram_byte_off,
    input  ls_type_t                     ram_ls_type,
    input  logic [data_w-1:0]            ram_wdata,
    output logic                         ram_done,
    output logic [data_w-1:0]            ram_rdata
);

    localparam int idx_w = $clog2(ram_words);

    logic [31:0]      mem [ram_words];
    logic             is_double;
    logic             is_signed;
    logic             second_beat;
    logic [idx_w-1:0] hi_index;
    logic [3:0]       lane_en;
    logic [31:0]      lane_data;
    logic [31:0]      lo_word;
    logic [31:0]      hi_word;

    // request lines are held by the controller until done
    assign is_double = (ram_ls_type[1:0] == 2'b11);
    assign is_signed = !ram_ls_type[2];
    assign hi_index  = ram_word_index + 1'b1;

    // byte lanes for the first beat, data replicated to every lane
    always_comb begin
        case (ram_ls_type[1:0])
            2'b00: begin
                lane_en   = 4'b0001 << ram_byte_off;
                lane_data = {4{ram_wdata[7:0]}};
            end
            2'b01: begin
                lane_en   = ram_byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{ram_wdata[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = ram_wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_start) begin
            if (ram_write) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (lane_en[lane]) begin
                        mem[ram_word_index][8*lane +: 8] <= lane_data[8*lane +: 8];
                    end
                end
            end else begin
                // addressed byte moves down to bit 0
                lo_word <= mem[ram_word_index] >> {ram_byte_off, 3'b000};
            end
        end
        // upper word of sd/ld
        if (second_beat) begin
            if (ram_write) begin
                mem[hi_index] <= ram_wdata[63:32];
            end else begin
                hi_word <= mem[hi_index];
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            second_beat <= 1'b0;
            ram_done    <= 1'b0;
        end else begin
            second_beat <= ram_start && is_double;
            ram_done    <= (ram_start && !is_double) || second_beat;
        end
    end

    // sign or zero extension from the access size
    always_comb begin
        case (ram_ls_type[1:0])
            2'b00:   ram_rdata = {{(data_w-8){is_signed & lo_word[7]}}, lo_word[7:0]};
            2'b01:   ram_rdata = {{(data_w-16){is_signed & lo_word[15]}}, lo_word[15:0]};
            2'b10:   ram_rdata = {{(data_w-32){is_signed & lo_word[31]}}, lo_word};
            default: ram_rdata = {hi_word, lo_word};
        endcase
    end

endmodule

// File: src/bus_slave_ctrl.sv
`timescale 1ns/1ps

module bus_slave_ctrl import soc_pkg::*; #(
    parameter int ram_words = default_ram_words
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic [addr_w-1:0]            bus_address,
    input  ls_type_t                     bus_ls_type,
    input  logic [data_w-1:0]            bus_write_data,
    input  logic                         bus_read_enable,
    input  logic                         bus_write_enable,
    input  logic                         key_valid,
    input  logic [7:0]                   key_ascii,
    input  logic                         ram_done,
    input  logic [data_w-1:0]            ram_rdata,
    input  logic [31:0]                  plic_rdata,
    output logic [data_w-1:0]            bus_read_data,
    output logic                         bus_read_done,
    output logic                         bus_write_done,
    output logic                         ram_start,
    output logic                         ram_write,
    output logic [$clog2(ram_words)-1:0] ram_word_index,
    output logic [1:0]                   ram_byte_off,
    output ls_type_t                     ram_ls_type,
    output logic [data_w-1:0]            ram_wdata,
    output logic                         plic_access,
    output logic                         plic_write,
    output logic [addr_w-1:0]            plic_offset,
    output logic [31:0]                  plic_wdata,
    output logic                         key_event
);

    localparam int idx_w = $clog2(ram_words);
    localparam logic [addr_w-1:0] ram_bytes = addr_w'(ram_words * 4);

    typedef enum logic [1:0] {st_idle, st_dispatch, st_wait} state_t;
    typedef enum logic [1:0] {tgt_none, tgt_ram, tgt_key, tgt_plic} target_t;

    state_t            state;
    target_t           target;
    target_t           target_dec;
    logic              req_new;
    logic              req_write;
    logic [addr_w-1:0] req_addr;
    ls_type_t          req_ls;
    logic [data_w-1:0] req_wdata;
    logic [addr_w-1:0] req_ram_rel;
    logic [addr_w-1:0] ram_rel;
    logic [addr_w-1:0] plic_rel;
    logic [7:0]        key_reg;

    // only one request in flight, new pulses come while idle
    assign req_new = (state == st_idle) && (bus_read_enable || bus_write_enable);

    // decode straight off the bus, stored once with the request
    assign ram_rel  = bus_address - ram_base;
    assign plic_rel = bus_address - plic_base;

    always_comb begin
        if (ram_rel < ram_bytes) begin
            target_dec = tgt_ram;
        end else if (bus_address == key_addr) begin
            target_dec = tgt_key;
        end else if (plic_rel < plic_span) begin
            target_dec = tgt_plic;
        end else begin
            target_dec = tgt_none;
        end
    end

    // request payload, master may change its lines after the pulse
    always_ff @(posedge CLOCK_50) begin
        if (req_new) begin
            req_addr  <= bus_address;
            req_ls    <= bus_ls_type;
            req_wdata <= bus_write_data;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            target         <= tgt_none;
            req_write      <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            key_reg        <= '0;
        end else begin
            // keyboard register, last code wins
            if (key_valid) begin
                key_reg <= key_ascii;
            end
            case (state)
                st_idle: begin
                    if (req_new) begin
                        state     <= st_dispatch;
                        target    <= target_dec;
                        req_write <= bus_write_enable;
                        if (bus_write_enable) begin
                            bus_write_done <= 1'b0;
                        end else begin
                            bus_read_done <= 1'b0;
                        end
                    end
                end
                st_dispatch: begin
                    state <= st_wait;
                    // target strobe is high this cycle
                    // non-RAM read data is ready now, claim clears at this edge
                    if (!req_write) begin
                        case (target)
                            tgt_key:  bus_read_data <= {{(data_w-8){1'b0}}, key_reg};
                            tgt_plic: bus_read_data <= {{(data_w-32){1'b0}}, plic_rdata};
                            tgt_none: bus_read_data <= '0;
                            default:  bus_read_data <= bus_read_data;
                        endcase
                    end
                end
                st_wait: begin
                    // RAM finishes on ram_done, the rest line up with a single-beat RAM
                    if (target != tgt_ram || ram_done) begin
                        state          <= st_idle;
                        bus_read_done  <= 1'b1;
                        bus_write_done <= 1'b1;
                        if (!req_write && target == tgt_ram) begin
                            bus_read_data <= ram_rdata;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // RAM side, held stable for the whole access
    assign req_ram_rel    = req_addr - ram_base;
    assign ram_start      = (state == st_dispatch) && (target == tgt_ram);
    assign ram_write      = req_write;
    assign ram_word_index = req_ram_rel[idx_w+1:2];
    assign ram_byte_off   = req_ram_rel[1:0];
    assign ram_ls_type    = req_ls;
    assign ram_wdata      = req_wdata;

    // interrupt controller side
    // writes to key_addr fall through with no effect
    assign plic_access = (state == st_dispatch) && (target == tgt_plic);
    assign plic_write  = req_write;
    assign plic_offset = req_addr - plic_base;
    assign plic_wdata  = req_wdata[31:0];

    // raises source 1
    assign key_event = key_valid;

endmodule

// File: src/periph_bus_top.sv
`timescale 1ns/1ps

module periph_bus_top import soc_pkg::*; #(
    parameter int ram_words   = default_ram_words,
    parameter int num_sources = default_num_sources
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic [addr_w-1:0]      bus_address,
    input  ls_type_t               bus_ls_type,
    input  logic [data_w-1:0]      bus_write_data,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic                   key_valid,
    input  logic [7:0]             key_ascii,
    input  logic [num_sources-1:0] ext_irq,
    output logic [data_w-1:0]      bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    output logic                   meip,
    output logic                   seip
);

    // controller to RAM
    logic                         ram_start;
    logic                         ram_write;
    logic [$clog2(ram_words)-1:0] ram_word_index;
    logic [1:0]                   ram_byte_off;
    ls_type_t                     ram_ls_type;
    logic [data_w-1:0]            ram_wdata;
    logic                         ram_done;
    logic [data_w-1:0]            ram_rdata;

    // controller to interrupt controller
    logic                         plic_access;
    logic                         plic_write;
    logic [addr_w-1:0]            plic_offset;
    logic [31:0]                  plic_wdata;
    logic [31:0]                  plic_rdata;
    logic                         key_event;

    bus_slave_ctrl #(.ram_words(ram_words)) u_ctrl (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_ls_type      (bus_ls_type),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .key_valid        (key_valid),
        .key_ascii        (key_ascii),
        .ram_done         (ram_done),
        .ram_rdata        (ram_rdata),
        .plic_rdata       (plic_rdata),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_start        (ram_start),
        .ram_write        (ram_write),
        .ram_word_index   (ram_word_index),
        .ram_byte_off     (ram_byte_off),
        .ram_ls_type      (ram_ls_type),
        .ram_wdata        (ram_wdata),
        .plic_access      (plic_access),
        .plic_write       (plic_write),
        .plic_offset      (plic_offset),
        .plic_wdata       (plic_wdata),
        .key_event        (key_event)
    );

    word_ram #(.ram_words(ram_words)) u_ram (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ram_start      (ram_start),
        .ram_write      (ram_write),
        .ram_word_index (ram_word_index),
        .ram_byte_off   (ram_byte_off),
        .ram_ls_type    (ram_ls_type),
        .ram_wdata      (ram_wdata),
        .ram_done       (ram_done),
        .ram_rdata      (ram_rdata)
    );

    plic_regs #(.num_sources(num_sources)) u_plic (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .plic_access (plic_access),
        .plic_write  (plic_write),
        .plic_offset (plic_offset),
        .plic_wdata  (plic_wdata),
        .key_event   (key_event),
        .ext_irq     (ext_irq),
        .plic_rdata  (plic_rdata),
        .meip        (meip),
        .seip        (seip)
    );

endmodule

// File: tests/periph_model.svh
`ifndef periph_model_svh
`define periph_model_svh

// byte image of the RAM, little endian
logic [7:0]             m_ram [ram_words*4];
// last key code delivered
logic [7:0]             m_key;
// interrupt controller state, id 0 never used
logic [prio_w-1:0]      m_prio [num_sources];
logic [num_sources-1:0] m_pending;
logic [num_sources-1:0] m_enable [2];
logic [prio_w-1:0]      m_threshold [2];

task automatic model_clear();
    m_key     = '0;
    m_pending = '0;
    for (int i = 0; i < num_sources; i++) begin
        m_prio[i] = '0;
    end
    for (int c = 0; c < 2; c++) begin
        m_enable[c]    = '0;
        m_threshold[c] = '0;
    end
endtask

// access size in bytes, from the low two type bits
function automatic int access_bytes(input ls_type_t ls);
    return 1 << ls[1:0];
endfunction

task automatic model_store(input int addr, input ls_type_t ls, input logic [63:0] data);
    for (int i = 0; i < access_bytes(ls); i++) begin
        m_ram[addr + i] = data[8*i +: 8];
    end
endtask

function automatic logic [63:0] model_load(input int addr, input ls_type_t ls);
    logic [63:0] raw;
    int          n;
    raw = '0;
    n   = access_bytes(ls);
    for (int i = 0; i < n; i++) begin
        raw[8*i +: 8] = m_ram[addr + i];
    end
    // signed loads copy the top bit of the access upward
    if (!ls[2] && n < 8 && raw[8*n-1]) begin
        raw = raw | ~((64'd1 << (8*n)) - 64'd1);
    end
    return raw;
endfunction

// key events pend source 1, bit 0 of the irq lines is dropped
task automatic model_events(input logic [num_sources-1:0] irq, input logic key,
                            input logic [7:0] ascii);
    m_pending = m_pending | (irq & ~num_sources'(1));
    if (key) begin
        m_key        = ascii;
        m_pending[1] = 1'b1;
    end
endtask

// highest priority above threshold, first id wins a tie
function automatic int model_claim(input int ctx);
    int best;
    best = 0;
    for (int i = 1; i < num_sources; i++) begin
        if (m_pending[i] && m_enable[ctx][i] && m_prio[i] > m_threshold[ctx]) begin
            if (best == 0 || m_prio[i] > m_prio[best]) begin
                best = i;
            end
        end
    end
    return best;
endfunction

`endif

// File: tests/tb_periph_bus.sv
`timescale 1ns/1ps

module tb_periph_bus import soc_pkg::*; ();

    localparam int ram_words   = default_ram_words;
    localparam int num_sources = default_num_sources;
    localparam int ram_bytes   = ram_words * 4;
    localparam int wait_limit  = 20;

    logic                   CLOCK_50;
    logic                   KEY0;
    logic [addr_w-1:0]      bus_address;
    ls_type_t               bus_ls_type;
    logic [data_w-1:0]      bus_write_data;
    logic                   bus_read_enable;
    logic                   bus_write_enable;
    logic                   key_valid;
    logic [7:0]             key_ascii;
    logic [num_sources-1:0] ext_irq;
    logic [data_w-1:0]      bus_read_data;
    logic                   bus_read_done;
    logic                   bus_write_done;
    logic                   meip;
    logic                   seip;

    `include "periph_model.svh"

    periph_bus_top dut (.*);

    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // one request with its done flag timing checked on the way
    task automatic bus_access(input logic write, input logic [addr_w-1:0] addr,
                              input ls_type_t ls, input logic [data_w-1:0] wdata,
                              output logic [data_w-1:0] rdata);
        int edges;
        int latency;
        latency = (addr < ram_bytes && ls[1:0] == 2'b11) ? 3 : 2;
        assert (bus_read_done && bus_write_done) else
            stop_on_error("bus still busy when a new request was due");
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = wdata;
        bus_write_enable = write;
        bus_read_enable  = !write;
        @(posedge CLOCK_50);
        #1;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        // request lines are free after the pulse
        bus_address    = $urandom;
        bus_ls_type    = ls_type_t'($urandom_range(0, 6));
        bus_write_data = {$urandom, $urandom};
        check_value(write ? "bus_write_done" : "bus_read_done", 0,
                    write ? bus_write_done : bus_read_done);
        check_value(write ? "bus_read_done" : "bus_write_done", 1,
                    write ? bus_read_done : bus_write_done);
        edges = 0;
        while (!(bus_read_done && bus_write_done)) begin
            assert (edges < wait_limit) else
                stop_on_error("timeout waiting for the bus done flags");
            @(posedge CLOCK_50);
            #1;
            edges++;
        end
        check_value("done latency", latency, edges);
        rdata = bus_read_data;
    endtask

    task automatic bus_write(input logic [addr_w-1:0] addr, input ls_type_t ls,
                             input logic [data_w-1:0] data);
        logic [data_w-1:0] ignored;
        bus_access(1'b1, addr, ls, data, ignored);
    endtask

    task automatic read_expect(input logic [addr_w-1:0] addr, input ls_type_t ls,
                               input logic [data_w-1:0] expected);
        logic [data_w-1:0] got;
        bus_access(1'b0, addr, ls, {$urandom, $urandom}, got);
        check_value($sformatf("bus_read_data at %h", addr), expected, got);
    endtask

    // controller register addresses
    function automatic logic [addr_w-1:0] prio_addr(input int id);
        return plic_base + addr_w'(4 * id);
    endfunction

    function automatic logic [addr_w-1:0] enable_addr(input int ctx);
        return plic_base + plic_enable_off + addr_w'(ctx) * plic_ctx_enable_stride;
    endfunction

    function automatic logic [addr_w-1:0] threshold_addr(input int ctx);
        return plic_base + plic_threshold_off + addr_w'(ctx) * plic_ctx_stride;
    endfunction

    function automatic logic [addr_w-1:0] claim_addr(input int ctx);
        return plic_base + plic_claim_off + addr_w'(ctx) * plic_ctx_stride;
    endfunction

    // one-cycle pulses on the key and irq inputs
    task automatic pulse_events(input logic [num_sources-1:0] irq, input logic key,
                                input logic [7:0] ascii);
        ext_irq   = irq;
        key_valid = key;
        key_ascii = ascii;
        @(posedge CLOCK_50);
        #1;
        ext_irq   = '0;
        key_valid = 1'b0;
        model_events(irq, key, ascii);
    endtask

    task automatic check_irq_lines();
        check_value("meip", model_claim(0) != 0, meip);
        check_value("seip", model_claim(1) != 0, seip);
    endtask

    // random priorities, enables and thresholds whose upper bits must be dropped
    task automatic configure_random();
        logic [31:0] value;
        for (int id = 1; id < num_sources; id++) begin
            value = $urandom;
            bus_write(prio_addr(id), ls_w, {$urandom, value});
            m_prio[id] = value[prio_w-1:0];
        end
        for (int ctx = 0; ctx < 2; ctx++) begin
            value = $urandom;
            bus_write(enable_addr(ctx), ls_w, {$urandom, value});
            m_enable[ctx] = value[num_sources-1:0];
            value = $urandom;
            bus_write(threshold_addr(ctx), ls_w, {$urandom, value});
            m_threshold[ctx] = value[prio_w-1:0];
        end
    endtask

    // claim until id 0 as each claim clears its pending bit
    task automatic drain_claims(input int ctx);
        int id;
        do begin
            id = model_claim(ctx);
            read_expect(claim_addr(ctx), ls_w, 64'(id));
            if (id != 0) begin
                m_pending[id] = 1'b0;
            end
        end while (id != 0);
        check_irq_lines();
    endtask

    initial begin
        logic [data_w-1:0] data;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] load_addr;
        ls_type_t          ls;
        ls_type_t          load_ls;
        logic [7:0]        code;
        void'($urandom(9));
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_ls_type      = ls_w;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_valid        = 1'b0;
        key_ascii        = '0;
        ext_irq          = '0;
        model_clear();
        repeat (5) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;

        // idle state out of reset
        check_value("bus_read_done", 1, bus_read_done);
        check_value("bus_write_done", 1, bus_write_done);
        check_value("bus_read_data", 0, bus_read_data);
        check_value("meip", 0, meip);
        check_value("seip", 0, seip);

        // whole RAM gets known contents first
        for (int w = 0; w < ram_words; w++) begin
            data = {$urandom, $urandom};
            bus_write(addr_w'(4 * w), ls_w, data);
            model_store(4 * w, ls_w, data);
        end

        // store and then load somewhere in the same double word
        for (int n = 0; n < 300; n++) begin
            ls   = ls_type_t'($urandom_range(0, 3));
            addr = addr_w'($urandom_range(0, ram_bytes - 1)) & ~addr_w'(access_bytes(ls) - 1);
            data = {$urandom, $urandom};
            bus_write(addr, ls, data);
            model_store(int'(addr), ls, data);
            load_ls   = ls_type_t'($urandom_range(0, 6));
            load_addr = (addr & ~addr_w'(7)) |
                        (addr_w'($urandom_range(0, 7)) & ~addr_w'(access_bytes(load_ls) - 1));
            read_expect(load_addr, load_ls, model_load(int'(load_addr), load_ls));
        end

        // keyboard register keeps the last code and ignores writes
        for (int k = 0; k < 4; k++) begin
            code = 8'($urandom);
            pulse_events('0, 1'b1, code);
            read_expect(key_addr, ls_w, {56'h0, code});
            bus_write(key_addr, ls_w, {$urandom, $urandom});
            read_expect(key_addr, ls_bu, {56'h0, m_key});
        end

        // register read-back
        for (int r = 0; r < 8; r++) begin
            configure_random();
            bus_write(prio_addr(0), ls_w, '1);
            for (int id = 0; id < num_sources; id++) begin
                read_expect(prio_addr(id), ls_w, 64'(m_prio[id]));
            end
            for (int ctx = 0; ctx < 2; ctx++) begin
                read_expect(enable_addr(ctx), ls_w, 64'(m_enable[ctx]));
                read_expect(threshold_addr(ctx), ls_w, 64'(m_threshold[ctx]));
            end
            read_expect(plic_base + plic_pending_off, ls_w, 64'(m_pending));
        end

        // unmapped space and unused controller offsets
        read_expect(addr_w'(ram_bytes), ls_d, '0);
        read_expect(plic_base + 32'h100, ls_w, '0);
        read_expect(plic_base + plic_span, ls_w, '0);
        bus_write(32'h2000_0000, ls_w, {$urandom, $urandom});
        for (int u = 0; u < 10; u++) begin
            read_expect(32'h2000_0000 | addr_w'($urandom_range(0, 32'h0fff_ffff)), ls_w, '0);
        end

        // interrupt outputs and then claims on both contexts
        for (int r = 0; r < 30; r++) begin
            configure_random();
            check_irq_lines();
            pulse_events(num_sources'($urandom), 1'($urandom_range(0, 1)), 8'($urandom));
            // outputs trail the pending update by one cycle
            @(posedge CLOCK_50);
            #1;
            check_irq_lines();
            read_expect(plic_base + plic_pending_off, ls_w, 64'(m_pending));
            drain_claims(0);
            drain_claims(1);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: flist.f
+incdir+tests
src/soc_pkg.sv
src/plic_target.sv
src/plic_regs.sv
src/word_ram.sv
src/bus_slave_ctrl.sv
src/periph_bus_top.sv
tests/tb_periph_bus.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_bus -f flist.f &&
./obj_dir/Vtb_periph_bus | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
